// ==== verilog.f ====
design/huff_pkg.sv
design/huff_ctrl.sv
design/least_finder.sv
design/tree_builder.sv
design/node_mem.sv
design/huff_tree_top.sv
test/huff_checker.sv
test/tb_huff_tree.sv

// ==== test/tb_huff_tree.sv ====
`timescale 1ns/10ps
module tb_huff_tree;
  localparam int num_syms = 16;
  localparam int weight_w = 16;
  localparam int max_depth = 12;  // Lower than 15 so a 16 leaf chain can pass it
  localparam int sym_w = $clog2(num_syms);
  localparam int id_w = huff_pkg::node_id_w;
  localparam int num_rows = 6;
  localparam int timeout_cycles = num_rows * (num_syms * (num_syms + 6) + 40);
  localparam logic [id_w-1:0] null_id = huff_pkg::null_node;
  localparam logic [id_w-1:0] sum_base = 9'h100; // Sum flag, index in the low bits

  logic                              clk, rst_n, freq_load, start;
  logic [sym_w-1:0]                  freq_sym;
  logic [weight_w-1:0]               freq_count;
  logic                              node_valid, done, err;
  logic [huff_pkg::node_idx_w-1:0]   node_idx;
  logic [id_w-1:0]                   node_left, node_right, root_id;
  logic [weight_w-1:0]               node_weight;
  logic [huff_pkg::depth_w-1:0]      node_depth;

  logic [0:num_syms-1][weight_w-1:0] freq_tab [num_rows]; // Symbol 0 is leftmost
  logic                              err_tab [num_rows];  // Run must end on err
  string                             name_tab [num_rows];

  logic [id_w-1:0]                   m_id [num_syms];     // Reference slot table
  logic [weight_w:0]                 m_wt [num_syms];     // Extra bit shows overflow
  logic                              m_live [num_syms];
  int                                m_dep [128];         // Depth per sum node
  int                                cycles, passed, failed;

  huff_tree_top #(.num_syms(num_syms), .weight_w(weight_w), .max_depth(max_depth)) i_dut (
    .clk(clk), .rst_n(rst_n), .freq_load(freq_load), .freq_sym(freq_sym),
    .freq_count(freq_count), .start(start), .node_valid(node_valid), .node_idx(node_idx),
    .node_left(node_left), .node_right(node_right), .node_weight(node_weight),
    .node_depth(node_depth), .done(done), .root_id(root_id), .err(err)
  );

  huff_checker #(.weight_w(weight_w)) i_checker (
    .clk(clk), .rst_n(rst_n), .node_valid(node_valid), .node_idx(node_idx),
    .node_left(node_left), .node_right(node_right), .node_weight(node_weight),
    .node_depth(node_depth), .done(done), .root_id(root_id), .err(err)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic fill_table();
    logic [31:0] seed;
    seed = 32'h5bef;
    name_tab[0] = "general";
    freq_tab[0] = {16'd5, 16'd9, 16'd12, 16'd13, 16'd16, 16'd45, 16'd0, 16'd3,
                   16'd7, 16'd1, 16'd0, 16'd22, 16'd8, 16'd4, 16'd2, 16'd6};
    err_tab[0]  = 1'b0;
    name_tab[1] = "equal";
    freq_tab[1] = {num_syms{16'd10}}; // Ties everywhere, balanced tree of depth 4
    err_tab[1]  = 1'b0;
    name_tab[2] = "single";
    freq_tab[2] = '0;
    freq_tab[2][5] = 16'd42;
    err_tab[2]  = 1'b0;
    name_tab[3] = "empty";
    freq_tab[3] = '0;
    err_tab[3]  = 1'b0;
    name_tab[4] = "fibonacci";
    freq_tab[4] = {16'd1, 16'd1, 16'd2, 16'd3, 16'd5, 16'd8, 16'd13, 16'd21,
                   16'd34, 16'd55, 16'd89, 16'd144, 16'd233, 16'd377, 16'd610, 16'd987};
    err_tab[4]  = 1'b1;                // Chain grows one level per merge
    name_tab[5] = "random";
    for (int s = 0; s < num_syms; s++) begin
      seed = xorshift32(seed);
      freq_tab[5][s] = weight_w'(seed[9:0]); // Small counts keep the total far from overflow
    end
    err_tab[5]  = 1'b0;
  endtask

  // Live slot with the lowest weight, lower slot first on a tie
  function automatic int lowest_slot(input int skip);
    int best;
    best = -1;
    for (int s = 0; s < num_syms; s++) begin
      if (m_live[s] && s != skip && (best < 0 || m_wt[s] < m_wt[best])) best = s;
    end
    return best;
  endfunction

  function automatic int depth_of(input logic [id_w-1:0] id);
    return id[huff_pkg::sum_flag_bit] ? m_dep[id[6:0]] : 0; // Leaves are depth 0
  endfunction

  task automatic build_reference(input int row, output logic fail);
    int n, live_n, s1, s2, d;
    logic [weight_w:0] total, sum;
    logic [id_w-1:0] right, root;
    logic stop;
    total = '0;
    for (int s = 0; s < num_syms; s++) begin
      m_id[s]   = id_w'(s);
      m_wt[s]   = {1'b0, freq_tab[row][s]};
      m_live[s] = (freq_tab[row][s] != '0); // Zero counts never enter the table
      total     = total + m_wt[s];
    end
    i_checker.begin_test(total[weight_w-1:0]);
    n = 0;
    fail = 1'b0;
    root = null_id;
    stop = 1'b0;
    while (!stop) begin
      live_n = 0;
      for (int s = 0; s < num_syms; s++) live_n += m_live[s];
      if (live_n == 0) begin
        stop = 1'b1;                       // Empty file ends with a null root
      end else if (live_n == 1 && n > 0) begin
        root = m_id[lowest_slot(-1)];      // Surviving slot holds the root
        stop = 1'b1;
      end else begin
        s1    = lowest_slot(-1);
        s2    = lowest_slot(s1);           // -1 when only one symbol exists
        right = (s2 < 0) ? null_id : m_id[s2];
        sum   = m_wt[s1];
        d     = depth_of(m_id[s1]);
        if (s2 >= 0) begin
          sum = sum + m_wt[s2];
          if (depth_of(m_id[s2]) > d) d = depth_of(m_id[s2]);
        end
        d = d + 1;
        if (d > max_depth || sum[weight_w]) begin
          fail = 1'b1;                     // Node is dropped and the run stops
          stop = 1'b1;
        end else begin
          i_checker.push_node(7'(n), m_id[s1], right, sum[weight_w-1:0], 4'(d));
          m_dep[n] = d;
          m_id[s1] = sum_base | id_w'(n);  // First child slot takes the new node
          m_wt[s1] = sum;
          if (s2 >= 0) m_live[s2] = 1'b0;
          n++;
        end
      end
    end
    i_checker.expect_end(fail, root);
  endtask

  task automatic load_row(input int row);
    for (int s = 0; s < num_syms; s++) begin
      @(negedge clk);
      freq_load  <= 1'b1;
      freq_sym   <= sym_w'(s);
      freq_count <= freq_tab[row][s];
    end
    @(negedge clk);
    freq_load <= 1'b0;
    start     <= 1'b1;
    @(negedge clk);
    start <= 1'b0;
  endtask

  task automatic run_test(input int row);
    int errs_before;
    logic exp_fail;
    errs_before = i_checker.errors;
    build_reference(row, exp_fail);
    if (exp_fail !== err_tab[row]) begin
      i_checker.report($sformatf("reference model and table disagree on the outcome of %s",
                                 name_tab[row]));
    end
    load_row(row);
    while (!i_checker.finished) @(posedge clk); // Timeout process guards this wait
    repeat (3) @(posedge clk);                  // FSM back to idle, stray strobes still caught
    if (i_checker.errors == errs_before) begin
      passed++;
      $display("Test %0d %s passed", row, name_tab[row]);
    end else begin
      failed++;
      $display("Test %0d %s failed with %0d errors", row, name_tab[row],
               i_checker.errors - errs_before);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run stopped after %0d cycles without finishing all tests", cycles);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    rst_n      = 1'b0;
    freq_load  = 1'b0;
    freq_sym   = '0;
    freq_count = '0;
    start      = 1'b0;
    passed     = 0;
    failed     = 0;
    fill_table();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n <= 1'b1;
    for (int r = 0; r < num_rows; r++) begin
      run_test(r);
    end
    $display("%0d tests, %0d passed, %0d failed, %0d check errors",
             num_rows, passed, failed, i_checker.errors);
    if (failed == 0 && i_checker.errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== test/huff_checker.sv ====
`timescale 1ns/10ps
module huff_checker #(
  parameter int weight_w = 16
) (
  input logic clk,
  input logic rst_n,
  input logic node_valid,
  input logic [huff_pkg::node_idx_w-1:0] node_idx,
  input logic [huff_pkg::node_id_w-1:0] node_left,
  input logic [huff_pkg::node_id_w-1:0] node_right,
  input logic [weight_w-1:0] node_weight,
  input logic [huff_pkg::depth_w-1:0] node_depth,
  input logic done,
  input logic [huff_pkg::node_id_w-1:0] root_id,
  input logic err
);
  // Expected node list, one entry per internal node in creation order
  logic [huff_pkg::node_idx_w-1:0] q_idx [$];
  logic [huff_pkg::node_id_w-1:0]  q_left [$];
  logic [huff_pkg::node_id_w-1:0]  q_right [$];
  logic [weight_w-1:0]             q_wt [$];
  logic [huff_pkg::depth_w-1:0]    q_dep [$];

  logic                          exp_fail;  // Run should end on err
  logic [huff_pkg::node_id_w-1:0] exp_root;
  logic [weight_w-1:0]           exp_total; // Sum of all loaded counts
  logic [weight_w-1:0]           last_wt;   // Weight of the newest node seen
  logic                          armed = 1'b0;
  logic                          finished = 1'b0;
  int                            errors = 0;

  task automatic report(input string msg);
    $display("Failure at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      $display("** Error: %s expected %h got %h at %0t ns", name, exp, got, $time);
      errors++;
    end
  endtask

  task automatic begin_test(input logic [weight_w-1:0] total);
    q_idx.delete();
    q_left.delete();
    q_right.delete();
    q_wt.delete();
    q_dep.delete();
    exp_total = total;
    exp_fail  = 1'b0;
    exp_root  = huff_pkg::null_node;
    last_wt   = '0;
    finished  = 1'b0;
    armed     = 1'b1; // Strobes are legal from here on
  endtask

  task automatic push_node(input logic [huff_pkg::node_idx_w-1:0] idx,
                           input logic [huff_pkg::node_id_w-1:0] left,
                           input logic [huff_pkg::node_id_w-1:0] right,
                           input logic [weight_w-1:0] wt,
                           input logic [huff_pkg::depth_w-1:0] dep);
    q_idx.push_back(idx);
    q_left.push_back(left);
    q_right.push_back(right);
    q_wt.push_back(wt);
    q_dep.push_back(dep);
  endtask

  task automatic expect_end(input logic fail, input logic [huff_pkg::node_id_w-1:0] root);
    exp_fail = fail;
    exp_root = root;
  endtask

  task automatic check_node();
    if (!armed || q_idx.size() == 0) begin
      report($sformatf("unexpected node_valid for node index %0d", node_idx));
    end else begin
      compare("node_idx", q_idx.pop_front(), node_idx);
      compare("node_left", q_left.pop_front(), node_left);
      compare("node_right", q_right.pop_front(), node_right);
      compare("node_weight", q_wt.pop_front(), node_weight);
      compare("node_depth", q_dep.pop_front(), node_depth);
      last_wt = node_weight;
    end
  endtask

  task automatic check_end(input logic got_err);
    if (!armed) begin
      report(got_err ? "err strobe outside a test" : "done strobe outside a test");
    end else begin
      if (got_err && !exp_fail) report("unexpected err strobe");
      if (!got_err && exp_fail) report("unexpected done strobe where err was expected");
      if (q_idx.size() != 0) report($sformatf("%0d node(s) missing at end of run", q_idx.size()));
      if (!got_err && !exp_fail) begin
        compare("root_id", exp_root, root_id);
        if (exp_root != huff_pkg::null_node) begin
          compare("root node_weight", exp_total, last_wt); // Root holds the whole count
        end
      end
      armed    = 1'b0;
      finished = 1'b1;
    end
  endtask

  // DUT outputs move on the rising edge, so look at them mid cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (node_valid) check_node();
      if (done) check_end(1'b0);
      if (err) check_end(1'b1);
    end
  end

endmodule

// ==== design/huff_tree_top.sv ====
`timescale 1ns/10ps
module huff_tree_top #(
  parameter int num_syms = 16,
  parameter int weight_w = 16,
  parameter int max_depth = 15
) (
  input  logic clk,
  input  logic rst_n,
  input  logic freq_load,
  input  logic [$clog2(num_syms)-1:0] freq_sym,
  input  logic [weight_w-1:0] freq_count,
  input  logic start,
  output logic node_valid,
  output logic [huff_pkg::node_idx_w-1:0] node_idx,
  output logic [huff_pkg::node_id_w-1:0] node_left,
  output logic [huff_pkg::node_id_w-1:0] node_right,
  output logic [weight_w-1:0] node_weight,
  output logic [huff_pkg::depth_w-1:0] node_depth,
  output logic done,
  output logic [huff_pkg::node_id_w-1:0] root_id,
  output logic err
);
  localparam int id_w = huff_pkg::node_id_w;
  localparam int idx_w = huff_pkg::node_idx_w;
  localparam int word_w = huff_pkg::node_word_w(weight_w);

  logic                           scan_go, merge_go, build_go;
  logic                           scan_done, build_done, depth_err;
  logic [$clog2(num_syms+1)-1:0]  live_count;
  logic [id_w-1:0]                new_id, least1, least2;
  logic [weight_w-1:0]            sum;
  logic [idx_w-1:0]               node_count, mem_addr;
  logic                           mem_en, mem_we;
  logic [word_w-1:0]              mem_wdata, mem_rdata;

  huff_ctrl #(.num_syms(num_syms)) i_ctrl (
    .clk(clk), .rst_n(rst_n), .start(start), .live_count(live_count),
    .scan_done(scan_done), .build_done(build_done), .depth_err(depth_err),
    .scan_go(scan_go), .merge_go(merge_go), .build_go(build_go), .new_id(new_id),
    .node_count(node_count), .done(done), .root_id(root_id), .err(err)
  );

  least_finder #(.num_syms(num_syms), .weight_w(weight_w)) i_finder (
    .clk(clk), .rst_n(rst_n), .freq_load(freq_load), .freq_sym(freq_sym),
    .freq_count(freq_count), .scan_go(scan_go), .merge_go(merge_go), .new_id(new_id),
    .scan_done(scan_done), .live_count(live_count), .least1(least1), .least2(least2),
    .sum(sum)
  );

  tree_builder #(.weight_w(weight_w), .max_depth(max_depth)) i_builder (
    .clk(clk), .rst_n(rst_n), .build_go(build_go), .least1(least1), .least2(least2),
    .sum(sum), .node_count(node_count), .mem_rdata(mem_rdata), .mem_en(mem_en),
    .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .build_done(build_done), .depth_err(depth_err), .node_valid(node_valid),
    .node_idx(node_idx), .node_left(node_left), .node_right(node_right),
    .node_weight(node_weight), .node_depth(node_depth)
  );

  node_mem #(.weight_w(weight_w)) i_mem (
    .clk(clk), .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
  );

endmodule

// ==== design/node_mem.sv ====
`timescale 1ns/10ps
module node_mem #(
  parameter int weight_w = 16
) (
  input  logic clk,
  input  logic mem_en,
  input  logic mem_we,
  input  logic [huff_pkg::node_idx_w-1:0] mem_addr,
  input  logic [huff_pkg::node_word_w(weight_w)-1:0] mem_wdata,
  output logic [huff_pkg::node_word_w(weight_w)-1:0] mem_rdata
);
  localparam int word_w = huff_pkg::node_word_w(weight_w);
  localparam int num_words = 2 ** huff_pkg::node_idx_w; // One word per sum node

  logic [word_w-1:0] mem [num_words];

  // Single port, write wins the port
  always_ff @(posedge clk) begin
    if (mem_en) begin
      if (mem_we) begin
        mem[mem_addr] <= mem_wdata;
      end else begin
        mem_rdata <= mem[mem_addr]; // Valid the cycle after the request
      end
    end
  end

endmodule

// ==== design/tree_builder.sv ====
`timescale 1ns/10ps
module tree_builder #(
  parameter int weight_w = 16,
  parameter int max_depth = 15
) (
  input  logic clk,
  input  logic rst_n,
  input  logic build_go,
  input  logic [huff_pkg::node_id_w-1:0] least1,
  input  logic [huff_pkg::node_id_w-1:0] least2,
  input  logic [weight_w-1:0] sum,
  input  logic [huff_pkg::node_idx_w-1:0] node_count,
  input  logic [huff_pkg::node_word_w(weight_w)-1:0] mem_rdata,
  output logic mem_en,
  output logic mem_we,
  output logic [huff_pkg::node_idx_w-1:0] mem_addr,
  output logic [huff_pkg::node_word_w(weight_w)-1:0] mem_wdata,
  output logic build_done,
  output logic depth_err,
  output logic node_valid,
  output logic [huff_pkg::node_idx_w-1:0] node_idx,
  output logic [huff_pkg::node_id_w-1:0] node_left,
  output logic [huff_pkg::node_id_w-1:0] node_right,
  output logic [weight_w-1:0] node_weight,
  output logic [huff_pkg::depth_w-1:0] node_depth
);
  localparam int id_w = huff_pkg::node_id_w;
  localparam int idx_w = huff_pkg::node_idx_w;
  localparam int dw = huff_pkg::depth_w;
  localparam int lft_lsb = huff_pkg::left_lsb(weight_w);
  localparam int rgt_lsb = huff_pkg::right_lsb(weight_w);

  typedef enum logic [2:0] {
    st_idle, st_new, st_rd1, st_dat1, st_rd2, st_dat2, st_write
  } state_t;
  state_t state;

  logic [id_w-1:0]     left_id, right_id; // Children of the node being built
  logic [weight_w-1:0] weight;
  logic [dw-1:0]       d1, d2;            // Child depths
  logic [dw:0]         depth;             // Extra bit catches the limit being passed
  logic [dw-1:0]       rd_depth;
  logic                l1_sum, l2_sum;
  logic                sat;

  function automatic logic is_sum(input logic [id_w-1:0] id);
    return id[huff_pkg::sum_flag_bit] && id != huff_pkg::null_node;
  endfunction

  assign l1_sum   = is_sum(left_id);
  assign l2_sum   = is_sum(right_id);
  assign rd_depth = mem_rdata[huff_pkg::depth_lsb +: dw];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (build_go) state <= st_new;
        st_new: begin
          if (l1_sum) begin
            state <= st_rd1;
          end else if (l2_sum) begin
            state <= st_rd2;
          end else begin
            state <= st_write; // Two leaves, nothing to look up
          end
        end
        st_rd1:  state <= st_dat1;
        st_dat1: state <= l2_sum ? st_rd2 : st_write;
        st_rd2:  state <= st_dat2;
        st_dat2: state <= st_write;
        st_write: state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && build_go) begin
      left_id  <= least1;
      right_id <= least2;
      weight   <= sum;
      d1       <= '0; // Leaves sit at depth 0
      d2       <= '0;
    end
    if (state == st_dat1) begin
      d1 <= rd_depth;
    end
    if (state == st_dat2) begin
      d2 <= rd_depth;
    end
  end

  assign depth      = {1'b0, (d1 > d2) ? d1 : d2} + 1'b1;
  assign sat        = &weight;                 // Saturated in the slot table
  assign build_done = (state == st_write);
  assign depth_err  = build_done && (depth > max_depth || sat);
  assign node_valid = build_done && !depth_err; // Bad node is neither stored nor shown

  assign mem_en = (state == st_rd1) || (state == st_rd2) || node_valid;
  assign mem_we = node_valid;

  always_comb begin
    case (state)
      st_rd1:  mem_addr = left_id[idx_w-1:0];
      st_rd2:  mem_addr = right_id[idx_w-1:0];
      default: mem_addr = node_count; // Write slot of the new node
    endcase
  end

  always_comb begin
    mem_wdata = '0;
    mem_wdata[lft_lsb +: id_w]                   = left_id;
    mem_wdata[rgt_lsb +: id_w]                   = right_id;
    mem_wdata[huff_pkg::weight_lsb +: weight_w]  = weight;
    mem_wdata[huff_pkg::depth_lsb +: dw]         = depth[dw-1:0];
  end

  assign node_idx    = node_count;
  assign node_left   = left_id;
  assign node_right  = right_id;
  assign node_weight = weight;
  assign node_depth  = depth[dw-1:0];

  // Read data comes back in the next cycle, which must stay free of writes
  a_no_write_on_data: assert property (
    @(posedge clk) disable iff (!rst_n) (mem_en && !mem_we) |=> !mem_we)
    else $error("node write in read data cycle");

endmodule

// ==== design/least_finder.sv ====
`timescale 1ns/10ps
module least_finder #(
  parameter int num_syms = 16,
  parameter int weight_w = 16
) (
  input  logic clk,
  input  logic rst_n,
  input  logic freq_load,
  input  logic [$clog2(num_syms)-1:0] freq_sym,
  input  logic [weight_w-1:0] freq_count,
  input  logic scan_go,
  input  logic merge_go,
  input  logic [huff_pkg::node_id_w-1:0] new_id,
  output logic scan_done,
  output logic [$clog2(num_syms+1)-1:0] live_count,
  output logic [huff_pkg::node_id_w-1:0] least1,
  output logic [huff_pkg::node_id_w-1:0] least2,
  output logic [weight_w-1:0] sum
);
  localparam int id_w = huff_pkg::node_id_w;
  localparam int slot_w = $clog2(num_syms);
  localparam int cnt_w = $clog2(num_syms + 1);

  logic [id_w-1:0]     slot_id [num_syms]; // Slot table
  logic [weight_w-1:0] slot_wt [num_syms];
  logic [num_syms-1:0] live;
  logic                stale;              // Table left over from the last run
  logic                scanning;
  logic [slot_w-1:0]   idx;                // Slot under test
  logic                b1_ok, b2_ok;       // Best two found so far
  logic [slot_w-1:0]   b1_slot, b2_slot;
  logic [id_w-1:0]     b1_id, b2_id;
  logic [weight_w-1:0] b1_wt, b2_wt;
  logic                take1, take2;
  logic [weight_w:0]   raw_sum;
  logic                ovf;

  // Strict compare keeps ties on the lower slot
  assign take1 = scanning && live[idx] && (!b1_ok || slot_wt[idx] < b1_wt);
  assign take2 = scanning && live[idx] && !take1 && (!b2_ok || slot_wt[idx] < b2_wt);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      live      <= '0;
      stale     <= 1'b0;
      scanning  <= 1'b0;
      idx       <= '0;
      scan_done <= 1'b0;
      b1_ok     <= 1'b0;
      b2_ok     <= 1'b0;
    end else begin
      scan_done <= 1'b0;
      if (freq_load) begin
        stale <= 1'b0;
        if (stale) begin
          live <= '0; // First load of a new file empties the table
        end
        if (freq_count != '0) begin
          live[freq_sym] <= 1'b1;
        end
      end
      if (merge_go && b2_ok) begin
        live[b2_slot] <= 1'b0; // Second child leaves the table
      end
      if (scan_go) begin
        scanning <= 1'b1;
        stale    <= 1'b1;
        idx      <= '0;
        b1_ok    <= 1'b0;
        b2_ok    <= 1'b0;
      end else if (scanning) begin
        if (take1) begin
          b1_ok <= 1'b1;
          b2_ok <= b1_ok; // Old best moves down
        end else if (take2) begin
          b2_ok <= 1'b1;
        end
        if (idx == slot_w'(num_syms - 1)) begin
          scanning  <= 1'b0;
          scan_done <= 1'b1; // num_syms + 1 cycles after scan_go
        end
        idx <= idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (merge_go) begin
      slot_id[b1_slot] <= new_id; // First child slot now holds the new node
      slot_wt[b1_slot] <= sum;
    end else if (freq_load && freq_count != '0) begin
      slot_id[freq_sym] <= id_w'(freq_sym); // Leaf id is the symbol code
      slot_wt[freq_sym] <= freq_count;
    end
    if (take1) begin
      b2_slot <= b1_slot;
      b2_id   <= b1_id;
      b2_wt   <= b1_wt;
      b1_slot <= idx;
      b1_id   <= slot_id[idx];
      b1_wt   <= slot_wt[idx];
    end else if (take2) begin
      b2_slot <= idx;
      b2_id   <= slot_id[idx];
      b2_wt   <= slot_wt[idx];
    end
  end

  always_comb begin
    live_count = '0;
    for (int s = 0; s < num_syms; s++) begin
      live_count = live_count + cnt_w'(live[s]);
    end
  end

  assign least1  = b1_ok ? b1_id : huff_pkg::null_node;
  assign least2  = b2_ok ? b2_id : huff_pkg::null_node;
  assign raw_sum = {1'b0, b1_wt} + {1'b0, (b2_ok ? b2_wt : {weight_w{1'b0}})};
  assign ovf     = raw_sum[weight_w];
  assign sum     = ovf ? '1 : raw_sum[weight_w-1:0]; // Saturated sum marks overflow

  // A merge needs a finished scan of the current table
  a_merge_after_scan: assert property (
    @(posedge clk) disable iff (!rst_n) scan_go |-> !merge_go until scan_done)
    else $error("merge_go before scan_done");

endmodule

// ==== design/huff_ctrl.sv ====
`timescale 1ns/10ps
module huff_ctrl #(
  parameter int num_syms = 16
) (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  input  logic [$clog2(num_syms+1)-1:0] live_count,
  input  logic scan_done,
  input  logic build_done,
  input  logic depth_err,
  output logic scan_go,
  output logic merge_go,
  output logic build_go,
  output logic [huff_pkg::node_id_w-1:0] new_id,
  output logic [huff_pkg::node_idx_w-1:0] node_count,
  output logic done,
  output logic [huff_pkg::node_id_w-1:0] root_id,
  output logic err
);
  localparam logic [1:0] sum_tag = 2'b10; // Sum flag set, null bit clear

  typedef enum logic [2:0] {st_idle, st_scan, st_build, st_merge, st_finish} state_t;
  state_t state;

  // Next sum node takes the next free index
  assign new_id = {sum_tag, node_count};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= st_idle;
      node_count <= '0;
      scan_go    <= 1'b0;
      merge_go   <= 1'b0;
      build_go   <= 1'b0;
      done       <= 1'b0;
      err        <= 1'b0;
      root_id    <= huff_pkg::null_node;
    end else begin
      scan_go  <= 1'b0; // All strobes last one cycle
      merge_go <= 1'b0;
      build_go <= 1'b0;
      done     <= 1'b0;
      err      <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin // Start outside idle is dropped
            node_count <= '0;
            scan_go    <= 1'b1;
            state      <= st_scan;
          end
        end
        st_scan: begin
          if (scan_done) begin
            if (live_count == '0) begin
              root_id <= huff_pkg::null_node; // Empty file, no tree
              done    <= 1'b1;
              state   <= st_finish;
            end else if (live_count == 1 && node_count != '0) begin
              // Survivor is always the node made by the last merge
              root_id <= {sum_tag, node_count - 1'b1};
              done    <= 1'b1;
              state   <= st_finish;
            end else if (&node_count) begin
              err   <= 1'b1; // Index space used up
              state <= st_finish;
            end else begin
              build_go <= 1'b1; // Also the single symbol case
              state    <= st_build;
            end
          end
        end
        st_build: begin
          if (build_done) begin
            if (depth_err) begin
              err   <= 1'b1;
              state <= st_finish;
            end else begin
              merge_go <= 1'b1;
              state    <= st_merge;
            end
          end
        end
        st_merge: begin
          node_count <= node_count + 1'b1; // Slots updated this cycle
          scan_go    <= 1'b1;
          state      <= st_scan;
        end
        st_finish: state <= st_idle; // done or err is high here
        default:   state <= st_idle;
      endcase
    end
  end

  // No build may start while a scan is still running
  a_scan_build_apart: assert property (
    @(posedge clk) disable iff (!rst_n) scan_go |-> !build_go until scan_done)
    else $error("build_go issued during a scan");

endmodule

// ==== design/huff_pkg.sv ====
package huff_pkg;

  // Node identifier: bit 8 flags a sum node, bit 7 is set only in the null code
  localparam int node_id_w = 9;
  localparam int sum_flag_bit = 8;
  localparam logic [node_id_w-1:0] null_node = 9'h180; // No child
  localparam int node_idx_w = 7;                       // Sum node index and memory address
  localparam int depth_w = 4;                          // Subtree height field

  // Node word is {left id, right id, weight, depth}, depth in the low bits
  localparam int depth_lsb = 0;
  localparam int weight_lsb = depth_lsb + depth_w;

  // Fields above the weight move with the weight width
  function automatic int right_lsb(input int weight_w);
    return weight_lsb + weight_w;
  endfunction

  function automatic int left_lsb(input int weight_w);
    return right_lsb(weight_w) + node_id_w;
  endfunction

  function automatic int node_word_w(input int weight_w);
    return left_lsb(weight_w) + node_id_w; // Full word width
  endfunction

endpackage
